// File: design/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 4;
    localparam int immWidth = 14;

    typedef logic [dataWidth-1:0] wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    typedef enum logic [1:0] {
        classAluReg  = 2'd0,
        classAluImm  = 2'd1,
        classBranch  = 2'd2,
        classSpecial = 2'd3
    } instrClassT;

    typedef enum logic [3:0] {
        funcAdd  = 4'd0,
        funcSub  = 4'd1,
        funcAnd  = 4'd2,
        funcOr   = 4'd3,
        funcXor  = 4'd4,
        funcNot  = 4'd5,
        funcSll  = 4'd6,
        funcSra  = 4'd7,
        funcSrl  = 4'd8,
        funcLoad = 4'd9
    } aluFuncT;

    // tested on rs, taken from the low two function bits
    typedef enum logic [1:0] {
        condAlways      = 2'd0,
        condNegative    = 2'd1,
        condNonNegative = 2'd2,
        condZero        = 2'd3
    } branchCondT;

    typedef struct packed {
        instrClassT           cls;
        aluFuncT              func;
        regAddrT              rs;
        regAddrT              rt;
        regAddrT              rd;
        logic [immWidth-1:0]  imm;
    } instrT;

    typedef enum logic [1:0] {
        fetch     = 2'd0,
        decode    = 2'd1,
        execute   = 2'd2,
        writeback = 2'd3
    } cpuStateT;

    typedef struct packed {
        cpuStateT state;
        logic     fetchGo;
        logic     useImm;
        logic     regWrite;
        logic     isBranch;
        logic     isOut;
    } ctrlT;

    // class 3 with every function bit set
    localparam logic [3:0] outFuncAll = 4'b1111;

endpackage

`default_nettype wire

// File: design/claAdder.sv
`default_nettype none

module claAdder #(
    parameter int adderWidth = 32
) (
    input  logic [adderWidth-1:0] a,
    input  logic [adderWidth-1:0] b,
    input  logic                  carryIn,
    output logic [adderWidth-1:0] sum
);
    localparam int groups = adderWidth / 4;

    logic [groups-1:0] groupCarry;

    if (adderWidth % 4 != 0) begin : genWidthCheck
        $error("claAdder: adderWidth %0d is not a multiple of 4", adderWidth);
    end

    assign groupCarry[0] = carryIn;

    for (genvar i = 0; i < groups; i++) begin : genGroup
        logic [3:0] g;
        logic [3:0] p;
        logic [3:0] c;

        assign g = a[4*i +: 4] & b[4*i +: 4];
        assign p = a[4*i +: 4] ^ b[4*i +: 4];

        // lookahead inside the group
        assign c[0] = groupCarry[i];
        assign c[1] = g[0] | (p[0] & c[0]);
        assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c[0]);
        assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                    | (p[2] & p[1] & p[0] & c[0]);

        assign sum[4*i +: 4] = p ^ c;

        // ripple into the next group, top group has no carry out
        if (i + 1 < groups) begin : genChain
            assign groupCarry[i+1] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                                   | (p[3] & p[2] & p[1] & g[0])
                                   | (p[3] & p[2] & p[1] & p[0] & c[0]);
        end
    end

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu (
    input  cpuPkg::aluFuncT func,
    input  cpuPkg::wordT    opA,
    input  cpuPkg::wordT    opB,
    output cpuPkg::wordT    result
);
    import cpuPkg::*;

    wordT addB;
    wordT addSum;
    logic addCarryIn;
    logic shiftOne;

    // subtract as a + ~b + 1
    assign addB = (func == funcSub) ? ~opB : opB;
    assign addCarryIn = (func == funcSub);

    claAdder #(
        .adderWidth(dataWidth)
    ) adder0 (
        .a(opA),
        .b(addB),
        .carryIn(addCarryIn),
        .sum(addSum)
    );

    // shifts move by a single bit at most
    assign shiftOne = opB[0];

    always_comb begin
        case (func)
            funcAdd,
            funcSub: begin
                result = addSum;
            end
            funcAnd:  result = opA & opB;
            funcOr:   result = opA | opB;
            funcXor:  result = opA ^ opB;
            funcNot:  result = ~opA;
            funcSll:  result = opA << shiftOne;
            funcSra:  result = wordT'($signed(opA) >>> shiftOne);
            funcSrl:  result = opA >> shiftOne;
            funcLoad: result = opB;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
`default_nettype none

module regFile (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::regAddrT readAddrA,
    input  cpuPkg::regAddrT readAddrB,
    output cpuPkg::wordT    readDataA,
    output cpuPkg::wordT    readDataB,
    input  logic            writeEnable,
    input  cpuPkg::regAddrT writeAddr,
    input  cpuPkg::wordT    writeData
);
    import cpuPkg::*;

    localparam int regCount = 1 << regAddrWidth;

    wordT regs [regCount];

    // r0 is an ordinary register here
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

// File: design/progMem.sv
`default_nettype none

module progMem #(
    parameter int progWords = 64
) (
    input  logic                         clk,
    input  logic                         run,
    input  logic                         progWrite,
    input  logic [$clog2(progWords)-1:0] progAddr,
    input  cpuPkg::wordT                 progData,
    input  logic [$clog2(progWords)-1:0] pc,
    output cpuPkg::wordT                 instr
);
    import cpuPkg::*;

    wordT mem [progWords];

    always_ff @(posedge clk) begin
        if (progWrite) begin
            mem[progAddr] <= progData;
        end
    end

    // instruction visible in the same cycle as the pc
    assign instr = mem[pc];

    // loading only while the core is held
    assert property (@(posedge clk) progWrite |-> !run)
        else $error("progMem: write while run is high");

    assert property (@(posedge clk) progWrite |-> (int'(progAddr) < progWords))
        else $error("progMem: write address %0d out of range", progAddr);

endmodule

`default_nettype wire

// File: design/datapath.sv
`default_nettype none

module datapath #(
    parameter int progWords = 64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  cpuPkg::ctrlT                 ctrl,
    input  cpuPkg::wordT                 instrWord,
    output logic [$clog2(progWords)-1:0] pc,
    output cpuPkg::instrT                ir,
    output logic                         outValid,
    output cpuPkg::wordT                 outValue
);
    import cpuPkg::*;

    localparam int pcWidth = $clog2(progWords);

    wordT regA;
    wordT regB;
    wordT aluOut;
    wordT readA;
    wordT readB;
    wordT immExt;
    wordT secondOp;
    wordT aluResult;
    aluFuncT aluFunc;
    logic taken;
    logic condMet;
    logic [pcWidth-1:0] pcNext;
    logic [pcWidth-1:0] pcTarget;

    regFile regs0 (
        .clk(clk),
        .reset(reset),
        .readAddrA(ir.rs),
        .readAddrB(ir.rt),
        .readDataA(readA),
        .readDataB(readB),
        .writeEnable(ctrl.regWrite),
        .writeAddr(ir.rd),
        .writeData(aluOut)
    );

    assign immExt = {{(dataWidth - immWidth){ir.imm[immWidth-1]}}, ir.imm};
    assign secondOp = ctrl.useImm ? immExt : regB;
    // OUT reuses the adder for rs+rt
    assign aluFunc = ctrl.isOut ? funcAdd : ir.func;

    alu alu0 (
        .func(aluFunc),
        .opA(regA),
        .opB(secondOp),
        .result(aluResult)
    );

    always_comb begin
        case (branchCondT'(ir.func[1:0]))
            condAlways:      condMet = 1'b1;
            condNegative:    condMet = regA[dataWidth-1];
            condNonNegative: condMet = !regA[dataWidth-1];
            default:         condMet = (regA == '0);
        endcase
    end

    // word offsets, relative to the following instruction
    assign pcNext = pc + pcWidth'(1);
    assign pcTarget = pcNext + immExt[pcWidth-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            ir <= '0;
            taken <= 1'b0;
            outValid <= 1'b0;
            outValue <= '0;
        end else begin
            if (ctrl.fetchGo) begin
                ir <= instrT'(instrWord);
            end
            if (ctrl.state == execute) begin
                taken <= ctrl.isBranch && condMet;
            end
            if (ctrl.state == writeback) begin
                pc <= taken ? pcTarget : pcNext;
            end
            // registered at the end of execute, so high through writeback
            outValid <= (ctrl.state == execute) && ctrl.isOut;
            if ((ctrl.state == execute) && ctrl.isOut) begin
                outValue <= aluResult;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.state == decode) begin
            regA <= readA;
            regB <= readB;
        end
        if (ctrl.state == execute) begin
            aluOut <= aluResult;
        end
    end

endmodule

`default_nettype wire

// File: design/controlFsm.sv
`default_nettype none

module controlFsm (
    input  logic          clk,
    input  logic          reset,
    input  logic          run,
    input  cpuPkg::instrT ir,
    output cpuPkg::ctrlT  ctrl
);
    import cpuPkg::*;

    cpuStateT state;
    logic isOutWord;
    logic writesRd;

    // one state per cycle, waits only in fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch;
        end else begin
            case (state)
                fetch: begin
                    if (run) begin
                        state <= decode;
                    end
                end
                decode:  state <= execute;
                execute: state <= writeback;
                default: state <= fetch;
            endcase
        end
    end

    assign isOutWord = (ir.cls == classSpecial) && (ir.func == outFuncAll);
    // other class 3 words fall through with no write
    assign writesRd = (ir.cls == classAluReg) || (ir.cls == classAluImm);

    always_comb begin
        ctrl.state = state;
        ctrl.fetchGo = (state == fetch) && run;
        ctrl.useImm = (ir.cls == classAluImm);
        ctrl.regWrite = (state == writeback) && writesRd;
        ctrl.isBranch = (ir.cls == classBranch);
        ctrl.isOut = isOutWord;
    end

    assert property (@(posedge clk) disable iff (reset) !$isunknown(state))
        else $error("controlFsm: state is unknown");

endmodule

`default_nettype wire

// File: design/cpuTop.sv
`default_nettype none

module cpuTop #(
    parameter int progWords = 64
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  logic                         progWrite,
    input  logic [$clog2(progWords)-1:0] progAddr,
    input  cpuPkg::wordT                 progData,
    output logic                         outValid,
    output cpuPkg::wordT                 outValue
);
    import cpuPkg::*;

    logic [$clog2(progWords)-1:0] pc;
    wordT instrWord;
    instrT ir;
    ctrlT ctrl;

    progMem #(
        .progWords(progWords)
    ) progMem0 (
        .clk(clk),
        .run(run),
        .progWrite(progWrite),
        .progAddr(progAddr),
        .progData(progData),
        .pc(pc),
        .instr(instrWord)
    );

    datapath #(
        .progWords(progWords)
    ) datapath0 (
        .clk(clk),
        .reset(reset),
        .ctrl(ctrl),
        .instrWord(instrWord),
        .pc(pc),
        .ir(ir),
        .outValid(outValid),
        .outValue(outValue)
    );

    controlFsm controlFsm0 (
        .clk(clk),
        .reset(reset),
        .run(run),
        .ir(ir),
        .ctrl(ctrl)
    );

endmodule

`default_nettype wire

// File: tb/tbPrograms.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

logic [31:0] rngState = 32'hdc7161f5;

function automatic logic [31:0] nextRandom();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
endfunction

// 13-bit magnitude, pushed below zero on request
function automatic int randImm(bit negative);
    int v;
    v = int'(nextRandom() % 8192);
    return negative ? v - 8192 : v;
endfunction

// field order: class, function, rs, rt, rd, immediate
function automatic wordT packWord(int cls, int func, int rs, int rt, int rd, int imm);
    return {cls[1:0], func[3:0], rs[3:0], rt[3:0], rd[3:0], imm[immWidth-1:0]};
endfunction

function automatic wordT encR(int func, int rd, int rs, int rt);
    return packWord(0, func, rs, rt, rd, 0);
endfunction

function automatic wordT encI(int func, int rd, int rs, int imm);
    return packWord(1, func, rs, 0, rd, imm);
endfunction

function automatic wordT encB(int cond, int rs, int offset);
    return packWord(2, cond, rs, 0, 0, offset);
endfunction

function automatic wordT encOut(int rs, int rt);
    return packWord(3, outFuncAll, rs, rt, 0, 0);
endfunction

function automatic wordT encSpecial(int func, int rd, int rs, int rt);
    return packWord(3, func, rs, rt, rd, 0);
endfunction

// always-taken branch back onto itself
function automatic wordT encHalt();
    return encB(condAlways, 0, -1);
endfunction

function automatic wordT aluModel(logic [3:0] f, wordT x, wordT y);
    case (f)
        4'd0: return x + y;
        4'd1: return x - y;
        4'd2: return x & y;
        4'd3: return x | y;
        4'd4: return x ^ y;
        4'd5: return ~x;
        4'd6: return y[0] ? {x[30:0], 1'b0} : x;
        4'd7: return y[0] ? {x[31], x[31:1]} : x;
        4'd8: return y[0] ? {1'b0, x[31:1]} : x;
        4'd9: return y;
        default: return '0;
    endcase
endfunction

// steps the program until its self-branch, queues every OUT sum
function automatic int runModel();
    wordT regs [16];
    instrT ins;
    wordT a;
    int immInt;
    int pc;
    int steps;
    int target;
    logic taken;
    logic done;
    foreach (regs[i]) regs[i] = '0;
    pc = 0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < 1000 && pc < prog.size()) begin
        ins = instrT'(prog[pc]);
        a = regs[ins.rs];
        immInt = int'($signed(ins.imm));
        taken = 1'b0;
        steps++;
        case (ins.cls)
            classAluReg: regs[ins.rd] = aluModel(ins.func, a, regs[ins.rt]);
            classAluImm: regs[ins.rd] = aluModel(ins.func, a, wordT'(immInt));
            classBranch: begin
                case (ins.func[1:0])
                    2'd0: taken = 1'b1;
                    2'd1: taken = a[31];
                    2'd2: taken = !a[31];
                    default: taken = (a == '0);
                endcase
            end
            default: begin
                if (ins.func == 4'hf) begin
                    expQ.push_back(a + regs[ins.rt]);
                end
            end
        endcase
        target = (pc + 1 + immInt) & (progWords - 1);
        if (taken && target == pc) begin
            done = 1'b1;
        end
        pc = taken ? target : ((pc + 1) & (progWords - 1));
    end
    return steps;
endfunction

`endif

// File: tb/tbCpu.sv
`default_nettype none

module tbCpu;
    timeunit 1ns;
    timeprecision 1ps;

    import cpuPkg::*;

    localparam int progWords = 64;
    localparam int addrWidth = $clog2(progWords);

    logic clk;
    logic reset;
    logic run;
    logic progWrite;
    logic [addrWidth-1:0] progAddr;
    wordT progData;
    logic outValid;
    wordT outValue;

    wordT prog [$];
    wordT expQ [$];
    wordT expHead;
    logic queueEmpty;
    int pulseCount = 0;
    int lowCycles = 0;
    int errorCount = 0;
    int checkedCount = 0;
    int testCount = 0;
    int cycleBudget = 60;
    int cyclesUsed = 0;

    `include "tbPrograms.svh"

    cpuTop #(
        .progWords(progWords)
    ) dut0 (
        .clk(clk),
        .reset(reset),
        .run(run),
        .progWrite(progWrite),
        .progAddr(progAddr),
        .progData(progData),
        .outValid(outValid),
        .outValue(outValue)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic void refreshHead();
        queueEmpty = (expQ.size() == 0);
        expHead = queueEmpty ? '0 : expQ[0];
    endfunction

    // retire one expected value per pulse
    always @(posedge clk) begin
        if (outValid) begin
            pulseCount++;
            if (expQ.size() > 0) begin
                void'(expQ.pop_front());
                checkedCount++;
            end
            refreshHead();
        end
        lowCycles <= run ? 0 : lowCycles + 1;
    end

    // sampled mid-cycle, away from the edges
    outMatches: assert property (@(negedge clk) disable iff (reset) outValid |-> outValue == expHead)
        else begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: outValue expected %h actual %h",
                $time, expHead, outValue);
        end

    noExtraPulse: assert property (@(negedge clk) disable iff (reset) outValid |-> !queueEmpty)
        else begin
            errorCount++;
            $display("outValid pulsed at %0t ns with no output expected", $time);
        end

    // an instruction in flight finishes within three cycles
    quietWhileHeld: assert property (@(negedge clk) disable iff (reset) lowCycles >= 3 |-> !outValid)
        else begin
            errorCount++;
            $display("outValid pulsed at %0t ns while run was held low", $time);
        end

    initial begin
        while (cyclesUsed < cycleBudget) begin
            @(posedge clk);
            cyclesUsed++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", cycleBudget);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic loadProgram();
        foreach (prog[i]) begin
            @(posedge clk);
            progWrite <= 1'b1;
            progAddr <= addrWidth'(i);
            progData <= prog[i];
        end
        @(posedge clk);
        progWrite <= 1'b0;
    endtask

    task automatic runTest(input string name, input bit pauses);
        int steps;
        int expected;
        int errorsBefore;
        int pauseLen;
        errorsBefore = errorCount;
        steps = runModel();
        expected = expQ.size();
        refreshHead();
        pulseCount = 0;
        cycleBudget += steps * 4 + prog.size() + 40;
        loadProgram();
        @(posedge clk);
        run <= 1'b1;
        while (pulseCount < expected) begin
            @(negedge clk);
            if (pauses && pulseCount < expected && nextRandom() % 6 == 0) begin
                pauseLen = 4 + int'(nextRandom() % 8);
                cycleBudget += pauseLen + 4;
                @(posedge clk);
                run <= 1'b0;
                repeat (pauseLen) @(posedge clk);
                run <= 1'b1;
            end
        end
        @(posedge clk);
        run <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        testCount++;
        $display("test %s: %0d outputs, %0d errors", name, expected, errorCount - errorsBefore);
    endtask

    task automatic buildRegImm();
        prog.delete();
        for (int f = 0; f < 10; f++) begin
            prog.push_back(encI(funcLoad, 1, 0, randImm(f % 3 == 0)));
            prog.push_back(encI(f, 2, 1, randImm(f % 2 == 1)));
            prog.push_back(encOut(2, 0));
        end
        prog.push_back(encHalt());
    endtask

    task automatic buildRegReg();
        // func, rs, rt per nibble
        logic [11:0] ops [14] = '{12'h012, 12'h132, 12'h123, 12'h214, 12'h323, 12'h414,
            12'h540, 12'h612, 12'h613, 12'h712, 12'h713, 12'h812, 12'h813, 12'h904};
        prog.delete();
        prog.push_back(encI(funcLoad, 1, 0, randImm(1)));
        prog.push_back(encI(funcLoad, 2, 0, randImm(0) | 1));
        prog.push_back(encI(funcLoad, 3, 0, randImm(0) & ~1));
        prog.push_back(encI(funcLoad, 4, 0, int'(nextRandom())));
        foreach (ops[i]) begin
            prog.push_back(encR(int'(ops[i][11:8]), 5, int'(ops[i][7:4]), int'(ops[i][3:0])));
            prog.push_back(encOut(5, 0));
        end
        prog.push_back(encHalt());
    endtask

    task automatic buildBranches();
        // condition, rs per nibble
        logic [7:0] fwd [7] = '{8'h01, 8'h11, 8'h12, 8'h22, 8'h21, 8'h33, 8'h32};
        prog.delete();
        // r1 negative, r2 positive, r3 zero, r5 r6 path markers
        prog.push_back(encI(funcLoad, 1, 0, randImm(1)));
        prog.push_back(encI(funcLoad, 2, 0, randImm(0) | 1));
        prog.push_back(encI(funcLoad, 3, 0, 0));
        prog.push_back(encI(funcLoad, 5, 0, randImm(0)));
        prog.push_back(encI(funcLoad, 6, 0, randImm(1)));
        prog.push_back(encI(funcLoad, 7, 0, 2));
        prog.push_back(encI(funcLoad, 8, 0, 1));
        prog.push_back(encI(funcLoad, 9, 0, -2));
        prog.push_back(encI(funcLoad, 10, 0, 1));
        foreach (fwd[i]) begin
            prog.push_back(encB(int'(fwd[i][7:4]), int'(fwd[i][3:0]), 1));
            prog.push_back(encOut(5, 0));
            prog.push_back(encOut(6, 0));
        end
        // backward loops, each taken then falling through
        prog.push_back(encOut(7, 0));
        prog.push_back(encR(funcSub, 7, 7, 8));
        prog.push_back(encB(condNonNegative, 7, -3));
        prog.push_back(encOut(9, 0));
        prog.push_back(encR(funcAdd, 9, 9, 8));
        prog.push_back(encB(condNegative, 9, -3));
        prog.push_back(encR(funcSub, 10, 10, 8));
        prog.push_back(encOut(10, 0));
        prog.push_back(encB(condZero, 10, -3));
        prog.push_back(encHalt());
    endtask

    task automatic buildCountdown();
        prog.delete();
        prog.push_back(encI(funcLoad, 1, 0, 12));
        prog.push_back(encI(funcLoad, 2, 0, 1));
        prog.push_back(encI(funcLoad, 3, 0, randImm(1)));
        prog.push_back(encOut(1, 3));
        prog.push_back(encR(funcSub, 1, 1, 2));
        prog.push_back(encB(condNonNegative, 1, -3));
        prog.push_back(encHalt());
    endtask

    task automatic buildResetCheck(input bit afterReset);
        prog.delete();
        if (!afterReset) begin
            prog.push_back(encI(funcLoad, 0, 0, randImm(0) | 1));
            prog.push_back(encI(funcLoad, 1, 0, randImm(1)));
            prog.push_back(encOut(0, 1));
        end else begin
            prog.push_back(encSpecial(3, 0, 2, 2));
            prog.push_back(encOut(0, 1));
            prog.push_back(encI(funcLoad, 1, 0, randImm(1)));
            prog.push_back(encSpecial(0, 1, 0, 0));
            prog.push_back(encOut(1, 0));
        end
        prog.push_back(encHalt());
    endtask

    initial begin
        reset = 1'b1;
        run = 1'b0;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        refreshHead();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        buildRegImm();
        runTest("register-immediate", 1'b0);
        buildRegReg();
        runTest("register-register", 1'b0);
        buildBranches();
        runTest("branches", 1'b0);
        buildCountdown();
        runTest("run held low", 1'b1);
        buildResetCheck(1'b0);
        runTest("registers before reset", 1'b0);
        buildResetCheck(1'b1);
        runTest("registers after reset", 1'b0);
        $display("tests %0d, outputs checked %0d, errors %0d",
            testCount, checkedCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+tb
design/cpuPkg.sv
design/claAdder.sv
design/alu.sv
design/regFile.sv
design/progMem.sv
design/datapath.sv
design/controlFsm.sv
design/cpuTop.sv
tb/tbCpu.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tbCpu
FILELIST  := all.f
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJDIR)
